// ==== build.f ====
+incdir+test
logic/mem_island_pkg.sv
logic/sram_bank.sv
logic/bank_arbiter.sv
logic/narrow_port.sv
logic/wide_port.sv
logic/memory_island_top.sv
test/tb_memory_island.sv

// ==== Makefile ====
# Verilator flow for the banked scratchpad

VERILATOR ?= verilator
FILELIST  ?= build.f
TOP       ?= tb_memory_island
DUT_TOP   ?= memory_island_top
BUILD_DIR ?= build
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(DUT_TOP)

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_ref_model.svh ====
/*
 * Reference byte memory, narrow/wide arbitration reference
 * and xorshift random source for the scratchpad testbench
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [7:0] ref_mem [1 << AddrWidth];

function automatic logic [31:0] xorshift32(input logic [31:0] x);
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   return x;
endfunction

// Returns {narrow grant, wide grant} for one bank
function automatic logic [1:0] arbitrate(input logic n_req, input logic w_req, input int cnt);
   if (n_req && w_req) begin
      return (cnt == PriorityWait) ? 2'b01 : 2'b10;
   end
   return {n_req, w_req};
endfunction

function automatic int next_count(input logic n_req, input logic w_req, input int cnt);
   if (n_req && w_req && cnt != PriorityWait) begin
      return cnt + 1;
   end
   return 0;
endfunction

function automatic logic [63:0] ref_read(input int base, input int nbytes);
   logic [63:0] v;
   v = '0;
   for (int i = 0; i < nbytes; i++) begin
      v[i*8 +: 8] = ref_mem[base + i];
   end
   return v;
endfunction

task automatic ref_write(input int base, input int nbytes, input logic [63:0] d,
                         input logic [7:0] strb);
   for (int i = 0; i < nbytes; i++) begin
      if (strb[i]) begin
         ref_mem[base + i] = d[i*8 +: 8];
      end
   end
endtask

`endif

// ==== test/tb_memory_island.sv ====
/*
 * Testbench for the banked scratchpad: command driver, grant and
 * response checker, directed and random tests, timeout
 */
`timescale 1ns/1ps
`default_nettype none

module tb_memory_island;
   import mem_island_pkg::*;

   `include "tb_ref_model.svh"

   typedef struct packed {
      logic       we;
      addr_t      addr;
      wide_data_t data;
      wide_strb_t strb;
   } cmd_t;

   typedef struct packed {
      logic       we;
      wide_data_t data;
   } resp_t;

   localparam int NumRequests   = 128 + 48 + 40 + 40 + 20 + 120;
   localparam int TimeoutCycles = NumRequests * (PriorityWait + 1) + 200;

   logic clk_i = 1'b0;
   logic rst_ni;
   logic narrow_req_i, narrow_gnt_o, narrow_we_i, narrow_rvalid_o;
   addr_t narrow_addr_i;
   narrow_data_t narrow_wdata_i, narrow_rdata_o;
   narrow_strb_t narrow_strb_i;
   logic wide_req_i, wide_gnt_o, wide_we_i, wide_rvalid_o;
   addr_t wide_addr_i;
   wide_data_t wide_wdata_i, wide_rdata_o;
   wide_strb_t wide_strb_i;

   cmd_t  n_cmds [$];
   cmd_t  w_cmds [$];
   resp_t n_exp [$];
   resp_t w_exp [$];
   int    prio_cnt [NumWideBanks];
   logic  n_granted, w_granted, n_gnt_prev, w_gnt_prev;
   int    err_cnt, check_cnt, test_cnt, test_err0, cycles;
   int    conflicts, wide_wins;
   logic [31:0] rng = 32'd45;

   memory_island_top DUT (.*);

   always #5 clk_i = ~clk_i;

   function logic [31:0] next_rand();
      rng = xorshift32(rng);
      return rng;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      check_cnt++;
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic push_narrow(input logic we, input addr_t a, input logic [31:0] d,
                              input logic [3:0] s);
      cmd_t c;
      c.we   = we;
      c.addr = a;
      c.data = {32'h0, d};
      c.strb = {4'h0, s};
      n_cmds.push_back(c);
   endtask

   task automatic push_wide(input logic we, input addr_t a, input wide_data_t d,
                            input wide_strb_t s);
      cmd_t c;
      c.we   = we;
      c.addr = a;
      c.data = d;
      c.strb = s;
      w_cmds.push_back(c);
   endtask

   task automatic wait_idle();
      do begin
         @(negedge clk_i);
      end while (n_cmds.size() || w_cmds.size() || n_exp.size() || w_exp.size()
                 || narrow_req_i || wide_req_i);
   endtask

   task automatic finish_test(input string name);
      wait_idle();
      test_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err0);
      test_err0 = err_cnt;
   endtask

   // Present the head of each command queue until it is granted
   always @(posedge clk_i) begin
      cycles++;
      if (cycles > TimeoutCycles) begin
         $display("Timeout: requests still pending after %0d cycles", cycles);
         $display("Test failed");
         $finish;
      end else begin
         if (n_granted) void'(n_cmds.pop_front());
         if (w_granted) void'(w_cmds.pop_front());
         narrow_req_i <= n_cmds.size() > 0;
         if (n_cmds.size() > 0) begin
            narrow_we_i    <= n_cmds[0].we;
            narrow_addr_i  <= n_cmds[0].addr;
            narrow_wdata_i <= n_cmds[0].data[31:0];
            narrow_strb_i  <= n_cmds[0].strb[3:0];
         end
         wide_req_i <= w_cmds.size() > 0;
         if (w_cmds.size() > 0) begin
            wide_we_i    <= w_cmds[0].we;
            wide_addr_i  <= w_cmds[0].addr;
            wide_wdata_i <= w_cmds[0].data;
            wide_strb_i  <= w_cmds[0].strb;
         end
      end
   end

   // Grants and responses are compared at the falling edge
   always @(negedge clk_i) begin : compare_proc
      logic       exp_n, exp_w, nr, wr;
      logic [1:0] g;
      resp_t      r;
      int         nbase, wbase;
      if (!rst_ni) begin
         n_granted  = 1'b0;
         w_granted  = 1'b0;
         n_gnt_prev = 1'b0;
         w_gnt_prev = 1'b0;
      end else begin
         check_value("narrow_rvalid_o", 64'(narrow_rvalid_o), 64'(n_gnt_prev));
         check_value("wide_rvalid_o", 64'(wide_rvalid_o), 64'(w_gnt_prev));
         if (narrow_rvalid_o && n_exp.size() == 0) begin
            $display("Narrow response arrived with no request pending");
            err_cnt++;
         end else if (narrow_rvalid_o) begin
            r = n_exp.pop_front();
            if (!r.we) check_value("narrow_rdata_o", 64'(narrow_rdata_o), r.data);
         end
         if (wide_rvalid_o && w_exp.size() == 0) begin
            $display("Wide response arrived with no request pending");
            err_cnt++;
         end else if (wide_rvalid_o) begin
            r = w_exp.pop_front();
            if (!r.we) check_value("wide_rdata_o", wide_rdata_o, r.data);
         end
         exp_n = 1'b0;
         exp_w = 1'b0;
         for (int b = 0; b < NumWideBanks; b++) begin
            nr = narrow_req_i && (narrow_addr_i[BankSelBit] == bank_sel_t'(b));
            wr = wide_req_i && (wide_addr_i[BankSelBit] == bank_sel_t'(b));
            g  = arbitrate(nr, wr, prio_cnt[b]);
            if (nr) exp_n = g[1];
            if (wr) exp_w = g[0];
            if (nr && wr) begin
               conflicts++;
               if (wide_gnt_o) wide_wins++;
            end
            prio_cnt[b] = next_count(nr, wr, prio_cnt[b]);
         end
         check_value("narrow_gnt_o", 64'(narrow_gnt_o), 64'(exp_n));
         check_value("wide_gnt_o", 64'(wide_gnt_o), 64'(exp_w));
         nbase = int'(narrow_addr_i) & ~3;
         wbase = int'(wide_addr_i) & ~7;
         if (exp_n) begin
            r.we   = narrow_we_i;
            r.data = ref_read(nbase, 4);
            n_exp.push_back(r);
            if (narrow_we_i) ref_write(nbase, 4, {32'h0, narrow_wdata_i}, {4'h0, narrow_strb_i});
         end
         if (exp_w) begin
            r.we   = wide_we_i;
            r.data = ref_read(wbase, 8);
            w_exp.push_back(r);
            if (wide_we_i) ref_write(wbase, 8, wide_wdata_i, wide_strb_i);
         end
         n_granted  = narrow_gnt_o;
         w_granted  = wide_gnt_o;
         n_gnt_prev = exp_n;
         w_gnt_prev = exp_w;
      end
   end

   initial begin
      addr_t a [24];
      int    c0, w0;
      rst_ni = 1'b0;
      narrow_req_i = 1'b0;
      narrow_we_i = 1'b0;
      narrow_addr_i = '0;
      narrow_wdata_i = '0;
      narrow_strb_i = '0;
      wide_req_i = 1'b0;
      wide_we_i = 1'b0;
      wide_addr_i = '0;
      wide_wdata_i = '0;
      wide_strb_i = '0;
      repeat (2) @(posedge clk_i);
      rst_ni <= 1'b1;
      repeat (5) @(negedge clk_i);

      // Fill pattern depends on every address bit
      for (int i = 0; i < 128; i++) begin
         push_wide(1'b1, addr_t'(i << 3), {~(32'(i) * 32'h9e37_79b1), 32'(i) ^ 32'ha5c3_0000},
                   8'hff);
      end
      finish_test("reset and fill");

      for (int i = 0; i < 24; i++) begin
         a[i] = addr_t'(next_rand()) & 10'h3fc;
         push_narrow(1'b1, a[i], next_rand(), 4'(next_rand()));
      end
      for (int i = 0; i < 24; i++) push_narrow(1'b0, a[i], '0, '0);
      finish_test("narrow strobed writes");

      for (int i = 0; i < 8; i++) begin
         a[i] = addr_t'(next_rand()) & 10'h3f8;
         push_wide(1'b1, a[i], {next_rand(), next_rand()}, 8'hff);
      end
      wait_idle();
      for (int i = 0; i < 8; i++) begin
         push_narrow(1'b0, a[i], '0, '0);
         push_narrow(1'b0, a[i] | 10'h4, '0, '0);
      end
      wait_idle();
      for (int i = 0; i < 8; i++) push_narrow(1'b1, a[i] | 10'h4, next_rand(), 4'hf);
      wait_idle();
      for (int i = 0; i < 8; i++) push_wide(1'b0, a[i], '0, '0);
      finish_test("wide and narrow halves");

      for (int i = 0; i < 20; i++) begin
         push_narrow(1'(next_rand()), addr_t'(next_rand()) & 10'h3f4, next_rand(), 4'hf);
         push_wide(1'(next_rand()), (addr_t'(next_rand()) & 10'h3f0) | 10'h8,
                   {next_rand(), next_rand()}, 8'hff);
      end
      finish_test("different banks");

      c0 = conflicts;
      w0 = wide_wins;
      for (int i = 0; i < 15; i++) begin
         push_narrow(1'(next_rand()), addr_t'(next_rand()) & 10'h3f4, next_rand(), 4'hf);
      end
      for (int i = 0; i < 5; i++) begin
         push_wide(1'(next_rand()), addr_t'(next_rand()) & 10'h3f0,
                   {next_rand(), next_rand()}, wide_strb_t'(next_rand()));
      end
      wait_idle();
      check_value("wide_gnt_o win count", 64'(wide_wins - w0),
                  64'((conflicts - c0) / (PriorityWait + 1)));
      finish_test("same bank priority");

      for (int i = 0; i < 60; i++) begin
         push_narrow(1'(next_rand()), addr_t'(next_rand()) & 10'h3fc, next_rand(),
                     4'(next_rand()));
         push_wide(1'(next_rand()), addr_t'(next_rand()), {next_rand(), next_rand()},
                   wide_strb_t'(next_rand()));
      end
      finish_test("mixed random");

      $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== logic/memory_island_top.sv ====
/*
 * Scratchpad top level: narrow port, wide port and the
 * wide banks they share
 */
`timescale 1ns/1ps
`default_nettype none

module memory_island_top (
   input  logic                          clk_i,
   input  logic                          rst_ni,

   input  logic                          narrow_req_i,
   output logic                          narrow_gnt_o,
   input  mem_island_pkg::addr_t         narrow_addr_i,
   input  logic                          narrow_we_i,
   input  mem_island_pkg::narrow_data_t  narrow_wdata_i,
   input  mem_island_pkg::narrow_strb_t  narrow_strb_i,
   output logic                          narrow_rvalid_o,
   output mem_island_pkg::narrow_data_t  narrow_rdata_o,

   input  logic                          wide_req_i,
   output logic                          wide_gnt_o,
   input  mem_island_pkg::addr_t         wide_addr_i,
   input  logic                          wide_we_i,
   input  mem_island_pkg::wide_data_t    wide_wdata_i,
   input  mem_island_pkg::wide_strb_t    wide_strb_i,
   output logic                          wide_rvalid_o,
   output mem_island_pkg::wide_data_t    wide_rdata_o
);
   import mem_island_pkg::*;

   logic [NumWideBanks-1:0][NumSubBanks-1:0] nb_req;
   word_addr_t                               nb_addr;
   logic                                     nb_we;
   narrow_data_t                             nb_wdata;
   narrow_strb_t                             nb_strb;
   logic [NumWideBanks-1:0]                  nb_gnt;

   logic [NumWideBanks-1:0]                  wb_req;
   word_addr_t                               wb_addr;
   logic                                     wb_we;
   wide_data_t                               wb_wdata;
   wide_strb_t                               wb_strb;
   logic [NumWideBanks-1:0]                  wb_gnt;

   // Both ports see the raw read data of every bank
   wide_data_t [NumWideBanks-1:0]            bank_rdata;

   narrow_port i_narrow_port (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .narrow_req_i    (narrow_req_i),
      .narrow_addr_i   (narrow_addr_i),
      .narrow_we_i     (narrow_we_i),
      .narrow_wdata_i  (narrow_wdata_i),
      .narrow_strb_i   (narrow_strb_i),
      .narrow_gnt_o    (narrow_gnt_o),
      .narrow_rvalid_o (narrow_rvalid_o),
      .narrow_rdata_o  (narrow_rdata_o),
      .bank_req_o      (nb_req),
      .bank_addr_o     (nb_addr),
      .bank_we_o       (nb_we),
      .bank_wdata_o    (nb_wdata),
      .bank_strb_o     (nb_strb),
      .bank_gnt_i      (nb_gnt),
      .bank_rdata_i    (bank_rdata)
   );

   wide_port i_wide_port (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .wide_req_i    (wide_req_i),
      .wide_addr_i   (wide_addr_i),
      .wide_we_i     (wide_we_i),
      .wide_wdata_i  (wide_wdata_i),
      .wide_strb_i   (wide_strb_i),
      .wide_gnt_o    (wide_gnt_o),
      .wide_rvalid_o (wide_rvalid_o),
      .wide_rdata_o  (wide_rdata_o),
      .bank_req_o    (wb_req),
      .bank_addr_o   (wb_addr),
      .bank_we_o     (wb_we),
      .bank_wdata_o  (wb_wdata),
      .bank_strb_o   (wb_strb),
      .bank_gnt_i    (wb_gnt),
      .bank_rdata_i  (bank_rdata)
   );

   for (genvar b = 0; b < NumWideBanks; b++) begin : gen_banks
      bank_arbiter i_bank (
         .clk_i          (clk_i),
         .rst_ni         (rst_ni),
         .narrow_req_i   (nb_req[b]),
         .narrow_addr_i  (nb_addr),
         .narrow_we_i    (nb_we),
         .narrow_wdata_i (nb_wdata),
         .narrow_strb_i  (nb_strb),
         .narrow_gnt_o   (nb_gnt[b]),
         .wide_req_i     (wb_req[b]),
         .wide_addr_i    (wb_addr),
         .wide_we_i      (wb_we),
         .wide_wdata_i   (wb_wdata),
         .wide_strb_i    (wb_strb),
         .wide_gnt_o     (wb_gnt[b]),
         .rdata_o        (bank_rdata[b])
      );
   end

endmodule

`default_nettype wire

// ==== logic/wide_port.sv ====
/*
 * Wide port: bank decode, grant select and the full-width
 * response from the registered bank select
 */
`timescale 1ns/1ps
`default_nettype none

module wide_port (
   input  logic                                clk_i,
   input  logic                                rst_ni,

   input  logic                                wide_req_i,
   input  mem_island_pkg::addr_t               wide_addr_i,
   input  logic                                wide_we_i,
   input  mem_island_pkg::wide_data_t          wide_wdata_i,
   input  mem_island_pkg::wide_strb_t          wide_strb_i,
   output logic                                wide_gnt_o,
   output logic                                wide_rvalid_o,
   output mem_island_pkg::wide_data_t          wide_rdata_o,

   output logic [mem_island_pkg::NumWideBanks-1:0] bank_req_o,
   output mem_island_pkg::word_addr_t          bank_addr_o,
   output logic                                bank_we_o,
   output mem_island_pkg::wide_data_t          bank_wdata_o,
   output mem_island_pkg::wide_strb_t          bank_strb_o,
   input  logic [mem_island_pkg::NumWideBanks-1:0] bank_gnt_i,
   input  mem_island_pkg::wide_data_t [mem_island_pkg::NumWideBanks-1:0] bank_rdata_i
);
   import mem_island_pkg::*;

   bank_sel_t bank_sel;
   bank_sel_t bank_sel_q;
   logic      rvalid_q;

   // Byte offset and sub-bank bits are ignored here
   assign bank_sel    = wide_addr_i[BankSelBit +: $bits(bank_sel_t)];
   assign bank_addr_o = wide_addr_i[WordLsb +: $bits(word_addr_t)];

   always_comb begin
      bank_req_o = '0;
      bank_req_o[bank_sel] = wide_req_i;
   end

   assign bank_we_o    = wide_we_i;
   assign bank_wdata_o = wide_wdata_i;
   assign bank_strb_o  = wide_strb_i;

   assign wide_gnt_o = wide_req_i & bank_gnt_i[bank_sel];

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         rvalid_q   <= 1'b0;
         bank_sel_q <= '0;
      end else begin
         rvalid_q <= wide_gnt_o;
         if (wide_gnt_o) begin
            bank_sel_q <= bank_sel;
         end
      end
   end

   assign wide_rvalid_o = rvalid_q;
   assign wide_rdata_o  = bank_rdata_i[bank_sel_q];

   // Every response traces back to a granted request one cycle earlier
   a_rvalid_after_gnt: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      wide_rvalid_o |-> $past(wide_req_i && wide_gnt_o)
   );

endmodule

`default_nettype wire

// ==== logic/narrow_port.sv ====
/*
 * Narrow port: bank and sub-bank decode, grant select and
 * read data steering through a delayed select
 */
`timescale 1ns/1ps
`default_nettype none

module narrow_port (
   input  logic                                clk_i,
   input  logic                                rst_ni,

   input  logic                                narrow_req_i,
   input  mem_island_pkg::addr_t               narrow_addr_i,
   input  logic                                narrow_we_i,
   input  mem_island_pkg::narrow_data_t        narrow_wdata_i,
   input  mem_island_pkg::narrow_strb_t        narrow_strb_i,
   output logic                                narrow_gnt_o,
   output logic                                narrow_rvalid_o,
   output mem_island_pkg::narrow_data_t        narrow_rdata_o,

   output logic [mem_island_pkg::NumWideBanks-1:0][mem_island_pkg::NumSubBanks-1:0] bank_req_o,
   output mem_island_pkg::word_addr_t          bank_addr_o,
   output logic                                bank_we_o,
   output mem_island_pkg::narrow_data_t        bank_wdata_o,
   output mem_island_pkg::narrow_strb_t        bank_strb_o,
   input  logic [mem_island_pkg::NumWideBanks-1:0] bank_gnt_i,
   input  mem_island_pkg::wide_data_t [mem_island_pkg::NumWideBanks-1:0] bank_rdata_i
);
   import mem_island_pkg::*;

   bank_sel_t bank_sel;
   bank_sel_t bank_sel_q;
   sub_sel_t  sub_sel;
   sub_sel_t  sub_sel_q;
   logic      rvalid_q;

   assign bank_sel    = narrow_addr_i[BankSelBit +: $bits(bank_sel_t)];
   assign sub_sel     = narrow_addr_i[SubSelBit +: $bits(sub_sel_t)];
   assign bank_addr_o = narrow_addr_i[WordLsb +: $bits(word_addr_t)];

   always_comb begin
      bank_req_o = '0;
      bank_req_o[bank_sel][sub_sel] = narrow_req_i;
   end

   assign bank_we_o    = narrow_we_i;
   assign bank_wdata_o = narrow_wdata_i;
   assign bank_strb_o  = narrow_strb_i;

   assign narrow_gnt_o = narrow_req_i & bank_gnt_i[bank_sel];

   // Select follows the SRAM latency so the response lines up
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         rvalid_q   <= 1'b0;
         bank_sel_q <= '0;
         sub_sel_q  <= '0;
      end else begin
         rvalid_q <= narrow_gnt_o;
         if (narrow_gnt_o) begin
            bank_sel_q <= bank_sel;
            sub_sel_q  <= sub_sel;
         end
      end
   end

   assign narrow_rvalid_o = rvalid_q;
   assign narrow_rdata_o  = bank_rdata_i[bank_sel_q][NarrowWidth*sub_sel_q +: NarrowWidth];

endmodule

`default_nettype wire

// ==== logic/bank_arbiter.sv ====
/*
 * One wide bank: narrow/wide priority counter, request muxing
 * onto the sub-banks and the sub-bank SRAMs
 */
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter (
   input  logic                                  clk_i,
   input  logic                                  rst_ni,

   input  logic [mem_island_pkg::NumSubBanks-1:0] narrow_req_i,
   input  mem_island_pkg::word_addr_t            narrow_addr_i,
   input  logic                                  narrow_we_i,
   input  mem_island_pkg::narrow_data_t          narrow_wdata_i,
   input  mem_island_pkg::narrow_strb_t          narrow_strb_i,
   output logic                                  narrow_gnt_o,

   input  logic                                  wide_req_i,
   input  mem_island_pkg::word_addr_t            wide_addr_i,
   input  logic                                  wide_we_i,
   input  mem_island_pkg::wide_data_t            wide_wdata_i,
   input  mem_island_pkg::wide_strb_t            wide_strb_i,
   output logic                                  wide_gnt_o,

   output mem_island_pkg::wide_data_t            rdata_o
);
   import mem_island_pkg::*;

   prio_cnt_t cnt_q;
   prio_cnt_t cnt_d;
   logic      narrow_any;
   logic      conflict;
   logic      wide_wins;

   assign narrow_any = |narrow_req_i;
   assign conflict   = narrow_any & wide_req_i;
   // Narrow keeps priority until the wide port has waited long enough
   assign wide_wins  = conflict & (cnt_q == prio_cnt_t'(PriorityWait));

   assign narrow_gnt_o = narrow_any & ~wide_wins;
   assign wide_gnt_o   = wide_req_i & (~conflict | wide_wins);

   always_comb begin
      cnt_d = '0;
      if (conflict && !wide_wins) begin
         cnt_d = cnt_q + prio_cnt_t'(1);
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_d;
      end
   end

   for (genvar j = 0; j < NumSubBanks; j++) begin : gen_sub_banks
      logic         narrow_sel;
      word_addr_t   sub_addr;
      logic         sub_we;
      narrow_data_t sub_wdata;
      narrow_strb_t sub_be;

      // Narrow winner reaches only its own sub-bank
      assign narrow_sel = narrow_req_i[j] & narrow_gnt_o;

      assign sub_addr  = narrow_sel ? narrow_addr_i : wide_addr_i;
      assign sub_we    = narrow_sel ? narrow_we_i : wide_we_i;
      assign sub_wdata = narrow_sel ? narrow_wdata_i
                                    : wide_wdata_i[j*NarrowWidth +: NarrowWidth];
      assign sub_be    = narrow_sel ? narrow_strb_i
                                    : wide_strb_i[j*NarrowStrbWidth +: NarrowStrbWidth];

      sram_bank i_sram (
         .clk_i   (clk_i),
         .req_i   (narrow_sel | wide_gnt_o),
         .we_i    (sub_we),
         .addr_i  (sub_addr),
         .wdata_i (sub_wdata),
         .be_i    (sub_be),
         .rdata_o (rdata_o[j*NarrowWidth +: NarrowWidth])
      );
   end

   // Narrow owns the bank alone in the first cycle of a conflict
   a_narrow_first_on_conflict: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      !conflict ##1 conflict |-> (narrow_gnt_o && !wide_gnt_o)
   );

   // A waiting wide request is never starved past the priority wait
   a_wide_no_starve: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      not ((wide_req_i && !wide_gnt_o) [* (PriorityWait + 1)])
   );

endmodule

`default_nettype wire

// ==== logic/sram_bank.sv ====
/*
 * Single-port narrow SRAM with byte enables and a
 * one-cycle registered read
 */
`timescale 1ns/1ps
`default_nettype none

module sram_bank (
   input  logic                          clk_i,
   input  logic                          req_i,
   input  logic                          we_i,
   input  mem_island_pkg::word_addr_t    addr_i,
   input  mem_island_pkg::narrow_data_t  wdata_i,
   input  mem_island_pkg::narrow_strb_t  be_i,
   output mem_island_pkg::narrow_data_t  rdata_o
);
   import mem_island_pkg::*;

   narrow_data_t mem_q [WordsPerBank];
   narrow_data_t rdata_q;

   always_ff @(posedge clk_i) begin
      if (req_i) begin
         if (we_i) begin
            for (int i = 0; i < NarrowStrbWidth; i++) begin
               // Only enabled bytes are touched
               if (be_i[i]) begin
                  mem_q[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
               end
            end
         end else begin
            rdata_q <= mem_q[addr_i];
         end
      end
   end

   assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== logic/mem_island_pkg.sv ====
/*
 * Shared widths, bank counts, address field positions and the
 * narrow/wide priority wait for the banked scratchpad
 */
`default_nettype none

package mem_island_pkg;

   // Port and bank geometry
   localparam int unsigned NarrowWidth     = 32;
   localparam int unsigned WideWidth       = 64;
   localparam int unsigned NarrowStrbWidth = NarrowWidth / 8;
   localparam int unsigned WideStrbWidth   = WideWidth / 8;
   localparam int unsigned NumSubBanks     = WideWidth / NarrowWidth;
   localparam int unsigned NumWideBanks    = 2;
   localparam int unsigned WordsPerBank    = 64;

   // Address layout: word | wide bank | sub-bank | byte offset
   localparam int unsigned SubSelBit  = $clog2(NarrowStrbWidth);
   localparam int unsigned BankSelBit = SubSelBit + $clog2(NumSubBanks);
   localparam int unsigned WordLsb    = BankSelBit + $clog2(NumWideBanks);
   localparam int unsigned AddrWidth  = WordLsb + $clog2(WordsPerBank);

   // Conflict cycles the wide port waits before it takes the bank
   localparam int unsigned PriorityWait = 2;

   typedef logic [NarrowWidth-1:0]     narrow_data_t;
   typedef logic [NarrowStrbWidth-1:0] narrow_strb_t;
   typedef logic [WideWidth-1:0]       wide_data_t;
   typedef logic [WideStrbWidth-1:0]   wide_strb_t;

   typedef logic [AddrWidth-1:0]               addr_t;
   typedef logic [$clog2(WordsPerBank)-1:0]    word_addr_t;
   typedef logic [$clog2(NumWideBanks)-1:0]    bank_sel_t;
   typedef logic [$clog2(NumSubBanks)-1:0]     sub_sel_t;
   typedef logic [$clog2(PriorityWait+1)-1:0]  prio_cnt_t;

endpackage

`default_nettype wire
